// File: calc_pkg.sv
`default_nettype none

package calc_pkg;

    ////////////////////////////////////////
    // Serial timing
    ////////////////////////////////////////

    localparam int CLK_FREQ     = 50_000_000;              // System clock, Hz
    localparam int BAUD         = 5_000_000;               // Serial rate
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;         // 10 clocks per bit
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);    // Bit-time counter width

    // Counter end points
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);   // Mid-bit

    ////////////////////////////////////////
    // Core program
    ////////////////////////////////////////

    localparam int PC_W = 3;                               // 8 ROM slots

    typedef enum logic [3:0] {
        op_ldi    = 4'h1,   // acc = imm
        op_ldc_in = 4'h2,   // cnt = operand
        op_jz     = 4'h3,   // Jump to imm if cnt == 0
        op_add_c  = 4'h4,   // acc += cnt
        op_djnz   = 4'h5,   // cnt--, jump to imm if not zero
        op_halt   = 4'hf    // Stop
    } opcode_t;

    // Fixed program layout
    localparam logic [PC_W-1:0] LOOP_ADDR = PC_W'(3);      // Add step
    localparam logic [PC_W-1:0] HALT_ADDR = PC_W'(5);      // Halt slot
    localparam logic [PC_W-1:0] PROG_LAST = HALT_ADDR;     // Highest address ever reached

    ////////////////////////////////////////
    // UART FSMs
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

`default_nettype wire

// File: program_rom.sv
`timescale 1ns/1ps
`default_nettype none

module program_rom (
    input  wire [calc_pkg::PC_W-1:0] pc,
    output calc_pkg::opcode_t        opcode,
    output logic [7:0]               imm
);

    // Sum of 1..operand, mod 256
    always_comb begin
        imm = 8'h00;
        case (pc)
            3'd0: opcode = calc_pkg::op_ldi;                // acc = 0
            3'd1: opcode = calc_pkg::op_ldc_in;             // cnt = operand
            3'd2: begin
                opcode = calc_pkg::op_jz;                   // Zero operand skips loop
                imm    = 8'(calc_pkg::HALT_ADDR);
            end
            3'd3: opcode = calc_pkg::op_add_c;              // Loop body
            3'd4: begin
                opcode = calc_pkg::op_djnz;                 // Back to add
                imm    = 8'(calc_pkg::LOOP_ADDR);
            end
            3'd5: opcode = calc_pkg::op_halt;
            default: opcode = calc_pkg::op_halt;            // Unused slots stop the core
        endcase
    end

endmodule

`default_nettype wire

// File: accum_core.sv
`timescale 1ns/1ps
`default_nettype none

module accum_core (
    input  wire        clk,
    input  wire        reset,
    input  wire        start,
    input  wire [7:0]  operand,
    output logic       running,
    output logic [7:0] result
);

    logic [calc_pkg::PC_W-1:0] pc;
    logic [calc_pkg::PC_W-1:0] pc_inc;
    logic [calc_pkg::PC_W-1:0] target;
    calc_pkg::opcode_t         opcode;
    logic [7:0]                imm;
    logic [7:0]                acc;
    logic [7:0]                cnt;
    logic [7:0]                opnd;     // Operand latched at start
    logic                      launch;

    program_rom u_rom (
        .pc     (pc),
        .opcode (opcode),
        .imm    (imm)
    );

    assign pc_inc = pc + 1'b1;
    assign target = imm[calc_pkg::PC_W-1:0];   // Jump field
    assign launch = start && !running;         // Start ignored mid-program
    assign result = acc;

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc      <= '0;
        end else if (!running) begin
            if (launch) begin
                running <= 1'b1;                       // Runs from next cycle
                pc      <= '0;
            end
        end else begin
            case (opcode)
                calc_pkg::op_ldi,
                calc_pkg::op_ldc_in,
                calc_pkg::op_add_c: pc <= pc_inc;
                calc_pkg::op_jz: begin
                    if (cnt == 8'd0) begin
                        pc <= target;
                    end else begin
                        pc <= pc_inc;
                    end
                end
                calc_pkg::op_djnz: begin
                    // Taken unless this decrement reaches zero
                    if (cnt != 8'd1) begin
                        pc <= target;
                    end else begin
                        pc <= pc_inc;
                    end
                end
                calc_pkg::op_halt: running <= 1'b0;    // pc parks on halt
                default: running <= 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (launch) begin
            opnd <= operand;
        end
        if (running) begin
            case (opcode)
                calc_pkg::op_ldi:    acc <= imm;
                calc_pkg::op_ldc_in: cnt <= opnd;
                calc_pkg::op_add_c:  acc <= acc + cnt;   // Wraps mod 256
                calc_pkg::op_djnz:   cnt <= cnt - 8'd1;
                default: ;                               // jz and halt touch no data
            endcase
        end
    end

    // Program never walks past its halt slot
    pc_in_range: assert property (
        @(posedge clk) disable iff (reset)
        running |-> (pc <= calc_pkg::PROG_LAST)
    ) else $error("accum_core pc %0d past last ROM address", pc);

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire        clk,
    input  wire        reset,
    input  wire        rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_error
);

    logic                       rxd_meta;
    logic                       rxd_sync;
    calc_pkg::rx_state_t        state;
    logic [calc_pkg::CNT_W-1:0] clk_cnt;
    logic [2:0]                 bit_idx;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= calc_pkg::rx_idle;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;                       // Strobes
            frame_error <= 1'b0;
            clk_cnt     <= clk_cnt + 1'b1;
            case (state)
                calc_pkg::rx_idle: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= calc_pkg::rx_start;   // Falling edge seen
                    end
                end
                calc_pkg::rx_start: begin
                    if (clk_cnt == calc_pkg::HALF_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch check at mid start bit
                        state   <= rxd_sync ? calc_pkg::rx_idle : calc_pkg::rx_data;
                    end
                end
                calc_pkg::rx_data: begin
                    if (clk_cnt == calc_pkg::BIT_LAST) begin
                        clk_cnt <= '0;
                        rx_byte <= {rxd_sync, rx_byte[7:1]};   // LSB first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= calc_pkg::rx_stop;
                        end
                    end
                end
                calc_pkg::rx_stop: begin
                    if (clk_cnt == calc_pkg::BIT_LAST) begin
                        clk_cnt     <= '0;
                        rx_valid    <= rxd_sync;       // Good stop bit
                        frame_error <= !rxd_sync;      // Byte discarded
                        state       <= calc_pkg::rx_idle;
                    end
                end
                default: state <= calc_pkg::rx_idle;
            endcase
        end
    end

    // One outcome per frame
    one_outcome: assert property (
        @(posedge clk) disable iff (reset)
        !(rx_valid && frame_error)
    ) else $error("uart_rx valid and framing error together");

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire       clk,
    input  wire       reset,
    input  wire       send,
    input  wire [7:0] tx_byte,
    output logic      txd,
    output logic      tx_busy
);

    calc_pkg::tx_state_t        state;
    logic [calc_pkg::CNT_W-1:0] clk_cnt;
    logic [2:0]                 bit_idx;
    logic [7:0]                 shift;    // Bit 0 on the line

    assign tx_busy = (state != calc_pkg::tx_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= calc_pkg::tx_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;                           // Line idles high
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                calc_pkg::tx_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    txd     <= 1'b1;
                    if (send) begin
                        shift <= tx_byte;
                        txd   <= 1'b0;                 // Start bit
                        state <= calc_pkg::tx_start;
                    end
                end
                calc_pkg::tx_start: begin
                    if (clk_cnt == calc_pkg::BIT_LAST) begin
                        clk_cnt <= '0;
                        txd     <= shift[0];
                        state   <= calc_pkg::tx_data;
                    end
                end
                calc_pkg::tx_data: begin
                    if (clk_cnt == calc_pkg::BIT_LAST) begin
                        clk_cnt <= '0;
                        shift   <= shift >> 1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;             // Stop bit
                            state <= calc_pkg::tx_stop;
                        end else begin
                            txd <= shift[1];           // Next data bit
                        end
                    end
                end
                calc_pkg::tx_stop: begin
                    if (clk_cnt == calc_pkg::BIT_LAST) begin
                        clk_cnt <= '0;
                        state   <= calc_pkg::tx_idle;  // Busy drops here
                    end
                end
                default: state <= calc_pkg::tx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top (
    input  wire  clk,
    input  wire  reset,
    input  wire  uart_rxd,
    output logic uart_txd,
    output logic busy,
    output logic frame_error
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       start;
    logic       running;
    logic       running_q;   // Edge detect on running
    logic [7:0] result;
    logic       pending;     // Result waiting for transmitter
    logic       send;
    logic       tx_busy;

    uart_rx u_rx (
        .clk         (clk),
        .reset       (reset),
        .rxd         (uart_rxd),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    accum_core u_core (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .operand (rx_byte),
        .running (running),
        .result  (result)
    );

    uart_tx u_tx (
        .clk     (clk),
        .reset   (reset),
        .send    (send),
        .tx_byte (result),
        .txd     (uart_txd),
        .tx_busy (tx_busy)
    );

    ////////////////////////////////////////
    // Start and send sequencing
    ////////////////////////////////////////

    // Byte dropped unless core fully idle
    assign start = rx_valid && !running && !running_q && !pending;
    assign send  = pending && !tx_busy;                // Waits out transmitter
    assign busy  = running || running_q || pending || tx_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            running_q <= 1'b0;
            pending   <= 1'b0;
        end else begin
            running_q <= running;
            if (running_q && !running) begin
                pending <= 1'b1;                       // Program just halted
            end else if (send) begin
                pending <= 1'b0;                       // One frame per result
            end
        end
    end

    // Transmitter free at send and takes the byte
    send_when_free: assert property (
        @(posedge clk) disable iff (reset)
        send |-> !tx_busy ##1 tx_busy
    ) else $error("calc_top send while transmitter busy");

endmodule

`default_nettype wire

// File: tb_calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calc_top;

    localparam int CLK_PERIOD  = 20;                       // ns
    localparam int BIT_CLKS    = calc_pkg::CLKS_PER_BIT;
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;            // Start, 8 data, stop
    localparam int LONG_PROG   = 800;                      // Operand 255 plus slack
    localparam int N_RUNS      = 30;                       // Operand runs over all tests
    localparam int RUN_CLKS    = LONG_PROG + 3 * FRAME_CLKS;
    localparam int WATCHDOG_NS = 2 * N_RUNS * RUN_CLKS * CLK_PERIOD;

    logic clk;
    logic reset;
    logic uart_rxd;
    logic uart_txd;
    logic busy;
    logic frame_error;
    int   fe_count = 0;                                    // Framing strobes seen

    calc_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .uart_rxd    (uart_rxd),
        .uart_txd    (uart_txd),
        .busy        (busy),
        .frame_error (frame_error)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Strobe counter, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && frame_error === 1'b1) begin
            fe_count++;
        end
    end

    ////////////////////////////////////////
    // Failure and compare helpers
    ////////////////////////////////////////

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        fail_run();
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Sum 1..x wrapped to a byte
    function automatic logic [7:0] model_sum(input logic [7:0] x);
        int s;
        s = int'(x) * (int'(x) + 1) / 2;
        return 8'(s);
    endfunction

    ////////////////////////////////////////
    // Serial driver and monitor
    ////////////////////////////////////////

    // One bit time on uart_rxd
    task automatic drive_bit(input logic b);
        @(posedge clk);
        #1 uart_rxd = b;
        repeat (BIT_CLKS - 1) @(posedge clk);
    endtask

    task automatic send_serial(input logic [7:0] data, input logic stop_ok);
        int i;
        drive_bit(1'b0);                                   // Start
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);                            // LSB first
        end
        drive_bit(stop_ok);
        if (!stop_ok) begin
            drive_bit(1'b1);                               // Line back to idle
        end
    endtask

    // Start edge, then mid-bit samples
    task automatic recv_serial(input int max_wait, output logic [7:0] data);
        int n;
        int i;
        n = 0;
        @(negedge clk);
        while (uart_txd !== 1'b0) begin
            if (n >= max_wait) begin
                report_failure("no result frame started on uart_txd");
            end
            n++;
            @(negedge clk);
        end
        repeat (BIT_CLKS / 2 - 1) @(negedge clk);          // Middle of start bit
        compare_bit("uart_txd start bit", uart_txd, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = uart_txd;
        end
        repeat (BIT_CLKS) @(negedge clk);
        compare_bit("uart_txd stop bit", uart_txd, 1'b1);
    endtask

    task automatic wait_busy_low(input int max_wait);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            if (n >= max_wait) begin
                report_failure("busy stayed high after the result frame");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic check_line_quiet(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            if (uart_txd !== 1'b1) begin
                report_failure(what);
            end
        end
    endtask

    // Byte in, one result out, line quiet after
    task automatic run_operand(input logic [7:0] op);
        logic [7:0] got;
        int         fe_before;
        fe_before = fe_count;
        send_serial(op, 1'b1);
        recv_serial(LONG_PROG + FRAME_CLKS, got);
        compare_byte("result byte", got, model_sum(op));
        wait_busy_low(2 * FRAME_CLKS);
        check_line_quiet(2 * FRAME_CLKS, "second frame after a single operand");
        compare_bit("frame_error on good byte", fe_count != fe_before, 1'b0);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic check_idle_outputs();
        compare_bit("uart_txd", uart_txd, 1'b1);
        compare_bit("busy", busy, 1'b0);
        compare_bit("frame_error", frame_error, 1'b0);
    endtask

    task automatic test_reset_state();
        repeat (7) begin
            @(negedge clk);
            check_idle_outputs();                          // Under reset
        end
        @(posedge clk);
        #1 reset = 1'b0;                                   // 8 edges in reset
        repeat (8) begin
            @(negedge clk);
            check_idle_outputs();
        end
    endtask

    task automatic test_directed();
        run_operand(8'd0);                                 // Loop skipped
        run_operand(8'd1);
        run_operand(8'd5);
        run_operand(8'd22);                                // 253, just under wrap
        run_operand(8'd255);                               // Longest program
    endtask

    task automatic test_random();
        logic [7:0] op;
        repeat (20) begin
            op = 8'($urandom);
            run_operand(op);
        end
    endtask

    // Second byte lands mid-program
    task automatic test_drop_busy();
        logic [7:0] got;
        send_serial(8'd255, 1'b1);
        send_serial(8'h3c, 1'b1);
        recv_serial(LONG_PROG + FRAME_CLKS, got);
        compare_byte("result byte", got, model_sum(8'd255));
        wait_busy_low(2 * FRAME_CLKS);
        check_line_quiet(3 * FRAME_CLKS, "dropped byte produced a result frame");
    endtask

    task automatic test_framing_error();
        int fe_before;
        fe_before = fe_count;
        send_serial(8'h5a, 1'b0);                          // Low stop bit
        check_line_quiet(LONG_PROG + 2 * FRAME_CLKS, "result frame after framing error");
        compare_byte("frame_error strobes", 8'(fe_count - fe_before), 8'd1);
        compare_bit("busy", busy, 1'b0);
        run_operand(8'd10);                                // Receiver recovers
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        uart_rxd = 1'b1;                                   // Idle line
        void'($urandom(32'hf01));
        test_reset_state();
        test_directed();
        test_random();
        test_drop_busy();
        test_framing_error();
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// File: vlog.f
calc_pkg.sv
program_rom.sv
accum_core.sv
uart_rx.sv
uart_tx.sv
calc_top.sv
tb_calc_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_calc_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
